/* common/gfx_pkg.sv */
// framebuffer graphics definitions for video timing, widths, pattern modes and pixel words
`default_nettype none

package gfx_pkg;

  localparam int color_width = 4;
  localparam int sram_addr_width = 20;
  localparam int sram_data_width = 16;

  // 640x480 at 60 Hz with a 25.175 MHz pixel clock
  localparam int h_visible = 640;
  localparam int h_front = 16;
  localparam int h_sync = 96;
  localparam int h_back = 48;

  localparam int v_visible = 480;
  localparam int v_front = 10;
  localparam int v_sync = 2;
  localparam int v_back = 33;

  typedef enum logic [1:0] {
    pat_gradient = 2'd0,  // red from x, green from y, blue from x xor y
    pat_checker  = 2'd1,  // 4x4 checkerboard
    pat_bars     = 2'd2,  // grey ramp repeating every 16 pixels
    pat_black    = 2'd3
  } pattern_mode_e;

  typedef struct packed {
    logic [3:0]             unused;
    logic [color_width-1:0] red;
    logic [color_width-1:0] green;
    logic [color_width-1:0] blue;
  } pixel_s;

  // the sram only sees raw words, the clients see colour fields
  typedef union packed {
    logic [sram_data_width-1:0] raw;
    pixel_s                     pix;
  } pixel_word_u;

endpackage

`default_nettype wire

/* common/sram_port_if.sv */
// request and read-return link between one sram client and the arbiter
`timescale 1ns/1ps
`default_nettype none

interface sram_port_if #(
  parameter int ADDR_WIDTH = gfx_pkg::sram_addr_width
);

  logic                 req;     // held until grant
  logic                 we;
  logic [ADDR_WIDTH-1:0] addr;
  gfx_pkg::pixel_word_u wdata;
  logic                 grant;   // one cycle per granted request
  logic                 rvalid;  // two cycles after a read grant
  gfx_pkg::pixel_word_u rdata;

  modport client (
    output req, we, addr, wdata,
    input  grant, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output grant, rvalid, rdata
  );

endinterface

`default_nettype wire

/* hdl/gfx_pattern_top.sv */
// pattern demo top that joins timing, writer, scanout reader and the shared sram arbiter
`timescale 1ns/1ps
`default_nettype none

module gfx_pattern_top #(
  parameter int H_VISIBLE  = gfx_pkg::h_visible,
  parameter int H_FRONT    = gfx_pkg::h_front,
  parameter int H_SYNC     = gfx_pkg::h_sync,
  parameter int H_BACK     = gfx_pkg::h_back,
  parameter int V_VISIBLE  = gfx_pkg::v_visible,
  parameter int V_FRONT    = gfx_pkg::v_front,
  parameter int V_SYNC     = gfx_pkg::v_sync,
  parameter int V_BACK     = gfx_pkg::v_back,
  parameter int ADDR_WIDTH = gfx_pkg::sram_addr_width,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                pixel_clk,
  input  logic                                rst_n,
  input  logic                                continuous_write,
  input  logic [1:0]                          pattern_mode,
  input  logic [gfx_pkg::sram_data_width-1:0] sram_rdata,
  output logic [ADDR_WIDTH-1:0]               sram_addr,
  output logic [gfx_pkg::sram_data_width-1:0] sram_wdata,
  output logic                                sram_ce_n,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  output logic [gfx_pkg::color_width-1:0]     vga_red,
  output logic [gfx_pkg::color_width-1:0]     vga_grn,
  output logic [gfx_pkg::color_width-1:0]     vga_blu,
  output logic                                vga_hsync,
  output logic                                vga_vsync,
  output logic                                vga_de,
  output logic                                write_busy,
  output logic [15:0]                         error_count
);

  logic de;
  logic hsync;
  logic vsync;
  logic frame_start;

  sram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_if ();
  sram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) wr_if ();

  vga_timing #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) vga_timing_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .de         (de),
    .hsync      (hsync),
    .vsync      (vsync),
    .frame_start(frame_start),
    .x_pos      (),
    .y_pos      ()
  );

  pattern_writer #(
    .H_VISIBLE (H_VISIBLE),
    .V_VISIBLE (V_VISIBLE),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) pattern_writer_i (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .continuous_write(continuous_write),
    .pattern_mode    (gfx_pkg::pattern_mode_e'(pattern_mode)),
    .write_busy      (write_busy),
    .mem             (wr_if.client)
  );

  scanout_reader #(
    .H_VISIBLE (H_VISIBLE),
    .V_VISIBLE (V_VISIBLE),
    .ADDR_WIDTH(ADDR_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) scanout_reader_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .de         (de),
    .hsync      (hsync),
    .vsync      (vsync),
    .frame_start(frame_start),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_de     (vga_de),
    .error_count(error_count),
    .mem        (rd_if.client)
  );

  sram_arbiter #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) sram_arbiter_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .sram_rdata(sram_rdata),
    .sram_addr (sram_addr),
    .sram_wdata(sram_wdata),
    .sram_ce_n (sram_ce_n),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .rd_port   (rd_if.arbiter),
    .wr_port   (wr_if.arbiter)
  );

endmodule

`default_nettype wire

/* hdl/sram_arbiter.sv */
// fixed-priority sram arbiter with registered pin drive and read-data return
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter #(
  parameter int ADDR_WIDTH = gfx_pkg::sram_addr_width
) (
  input  logic                                pixel_clk,
  input  logic                                rst_n,
  input  logic [gfx_pkg::sram_data_width-1:0] sram_rdata,
  output logic [ADDR_WIDTH-1:0]               sram_addr,
  output logic [gfx_pkg::sram_data_width-1:0] sram_wdata,
  output logic                                sram_ce_n,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  sram_port_if.arbiter                        rd_port,
  sram_port_if.arbiter                        wr_port
);

  logic                 rd_pin;    // read is on the pins this cycle
  logic                 rd_ret;
  gfx_pkg::pixel_word_u rdata_q;

  // the reader always wins; the writer fills the cycles left over
  assign rd_port.grant = rd_port.req;
  assign wr_port.grant = wr_port.req && !rd_port.req;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      rd_pin    <= 1'b0;
      rd_ret    <= 1'b0;
    end else begin
      sram_ce_n <= !(rd_port.grant || wr_port.grant);
      sram_oe_n <= !rd_port.grant;
      sram_we_n <= !wr_port.grant;
      rd_pin    <= rd_port.grant;
      rd_ret    <= rd_pin;
    end
  end

  always_ff @(posedge pixel_clk) begin
    sram_addr  <= rd_port.req ? rd_port.addr : wr_port.addr;
    sram_wdata <= wr_port.wdata.raw;
  end

  // the async sram output has settled by the end of the pin cycle
  always_ff @(posedge pixel_clk) begin
    if (rd_pin) rdata_q.raw <= sram_rdata;
  end

  assign rd_port.rvalid = rd_ret;
  assign rd_port.rdata  = rdata_q;

  assign wr_port.rvalid = 1'b0;  // writes complete at grant
  assign wr_port.rdata  = rdata_q;

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
// raster counters with active-low syncs, display enable and a frame start strobe
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter  int H_VISIBLE = gfx_pkg::h_visible,
  parameter  int H_FRONT   = gfx_pkg::h_front,
  parameter  int H_SYNC    = gfx_pkg::h_sync,
  parameter  int H_BACK    = gfx_pkg::h_back,
  parameter  int V_VISIBLE = gfx_pkg::v_visible,
  parameter  int V_FRONT   = gfx_pkg::v_front,
  parameter  int V_SYNC    = gfx_pkg::v_sync,
  parameter  int V_BACK    = gfx_pkg::v_back,
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK,
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK,
  localparam int HW        = $clog2(H_TOTAL),
  localparam int VW        = $clog2(V_TOTAL)
) (
  input  logic          pixel_clk,
  input  logic          rst_n,
  output logic          de,
  output logic          hsync,
  output logic          vsync,
  output logic          frame_start,
  output logic [HW-1:0] x_pos,
  output logic [VW-1:0] y_pos
);

  logic h_last;
  logic v_last;

  assign h_last = (x_pos == HW'(H_TOTAL - 1));
  assign v_last = (y_pos == VW'(V_TOTAL - 1));

  // start in vertical front porch so the reader gets a whole blanking period to prefetch
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x_pos <= '0;
      y_pos <= VW'(V_VISIBLE);
    end else begin
      if (h_last) begin
        x_pos <= '0;
        y_pos <= v_last ? '0 : y_pos + 1'b1;
      end else begin
        x_pos <= x_pos + 1'b1;
      end
    end
  end

  assign de = (x_pos < HW'(H_VISIBLE)) && (y_pos < VW'(V_VISIBLE));

  assign hsync = !((x_pos >= HW'(H_VISIBLE + H_FRONT)) &&
                   (x_pos < HW'(H_VISIBLE + H_FRONT + H_SYNC)));
  assign vsync = !((y_pos >= VW'(V_VISIBLE + V_FRONT)) &&
                   (y_pos < VW'(V_VISIBLE + V_FRONT + V_SYNC)));

  assign frame_start = (x_pos == '0) && (y_pos == VW'(V_VISIBLE));  // first blanking cycle

endmodule

`default_nettype wire

/* pattern/pattern_writer.sv */
// pattern writer that fills the framebuffer with the selected test pattern
`timescale 1ns/1ps
`default_nettype none

module pattern_writer #(
  parameter  int H_VISIBLE  = gfx_pkg::h_visible,
  parameter  int V_VISIBLE  = gfx_pkg::v_visible,
  parameter  int ADDR_WIDTH = gfx_pkg::sram_addr_width,
  localparam int XW         = $clog2(H_VISIBLE),
  localparam int YW         = $clog2(V_VISIBLE)
) (
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  logic                   continuous_write,
  input  gfx_pkg::pattern_mode_e pattern_mode,
  output logic                   write_busy,
  sram_port_if.client            mem
);

  logic [XW-1:0]          x;
  logic [YW-1:0]          y;
  logic [15:0]            x_ext;
  logic [15:0]            y_ext;
  logic                   x_last;
  logic                   last;
  gfx_pkg::pattern_mode_e mode;
  gfx_pkg::pixel_word_u   word;

  assign x_ext  = 16'(x);
  assign y_ext  = 16'(y);
  assign x_last = (x == XW'(H_VISIBLE - 1));
  assign last   = x_last && (y == YW'(V_VISIBLE - 1));

  always_comb begin
    word.raw = '0;
    case (mode)
      gfx_pkg::pat_gradient: begin
        word.pix.red   = x_ext[3:0];
        word.pix.green = y_ext[3:0];
        word.pix.blue  = x_ext[3:0] ^ y_ext[3:0];
      end
      gfx_pkg::pat_checker: begin
        if (x_ext[2] != y_ext[2]) begin
          word.pix.red   = '1;
          word.pix.green = '1;
          word.pix.blue  = '1;
        end
      end
      gfx_pkg::pat_bars: begin
        word.pix.red   = x_ext[3:0];
        word.pix.green = x_ext[3:0];
        word.pix.blue  = x_ext[3:0];
      end
      default: begin
      end
    endcase
  end

  // mode is resampled whenever a pass begins, including a continuous restart
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      write_busy <= 1'b0;
      x          <= '0;
      y          <= '0;
      mode       <= gfx_pkg::pat_black;
    end else if (!write_busy) begin
      if (continuous_write) begin
        write_busy <= 1'b1;
        x          <= '0;
        y          <= '0;
        mode       <= pattern_mode;
      end
    end else if (mem.grant) begin
      if (last) begin
        write_busy <= continuous_write;  // idle unless still asked to repeat
        x          <= '0;
        y          <= '0;
        mode       <= pattern_mode;
      end else if (x_last) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign mem.req   = write_busy;
  assign mem.we    = 1'b1;
  assign mem.addr  = ADDR_WIDTH'({y, x});
  assign mem.wdata = word;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the simulator's
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_gfx_pattern \
  -f vlog.f \
  -o tb_gfx_pattern

./obj_dir/tb_gfx_pattern

/* scanout/scanout_reader.sv */
// scanout reader that prefetches the framebuffer in raster order and drives the pixel outputs
`timescale 1ns/1ps
`default_nettype none

module scanout_reader #(
  parameter  int H_VISIBLE  = gfx_pkg::h_visible,
  parameter  int V_VISIBLE  = gfx_pkg::v_visible,
  parameter  int ADDR_WIDTH = gfx_pkg::sram_addr_width,
  parameter  int FIFO_DEPTH = 8,
  localparam int XW         = $clog2(H_VISIBLE),
  localparam int YW         = $clog2(V_VISIBLE),
  localparam int PW         = $clog2(FIFO_DEPTH),
  localparam int CW         = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                            pixel_clk,
  input  logic                            rst_n,
  input  logic                            de,
  input  logic                            hsync,
  input  logic                            vsync,
  input  logic                            frame_start,
  output logic [gfx_pkg::color_width-1:0] vga_red,
  output logic [gfx_pkg::color_width-1:0] vga_grn,
  output logic [gfx_pkg::color_width-1:0] vga_blu,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic                            vga_de,
  output logic [15:0]                     error_count,
  sram_port_if.client                     mem
);

  gfx_pkg::pixel_s fifo_mem [FIFO_DEPTH];
  gfx_pkg::pixel_s head;
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic [CW-1:0]   inflight;  // granted reads whose data has not returned
  logic [CW:0]     pending;
  logic [XW-1:0]   fetch_x;
  logic [YW-1:0]   fetch_y;
  logic            fetch_done;
  logic            push;
  logic            pop;
  logic            underflow;

  assign push      = mem.rvalid;
  assign pop       = de && (count != '0);
  assign underflow = de && (count == '0);
  assign pending   = {1'b0, count} + {1'b0, inflight};
  assign head      = fifo_mem[rd_ptr];

  // reserve fifo space for every read in flight, so a return never finds it full
  assign mem.req   = !fetch_done && !frame_start && (pending < (CW + 1)'(FIFO_DEPTH));
  assign mem.we    = 1'b0;
  assign mem.addr  = ADDR_WIDTH'({fetch_y, fetch_x});
  assign mem.wdata = '0;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      inflight   <= '0;
      fetch_x    <= '0;
      fetch_y    <= '0;
      fetch_done <= 1'b0;
    end else begin
      inflight <= inflight + CW'(mem.grant) - CW'(mem.rvalid);
      if (frame_start) begin
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        count      <= '0;
        fetch_x    <= '0;
        fetch_y    <= '0;
        fetch_done <= 1'b0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + CW'(push) - CW'(pop);
        if (mem.grant) begin
          if (fetch_x == XW'(H_VISIBLE - 1)) begin
            fetch_x <= '0;
            if (fetch_y == YW'(V_VISIBLE - 1)) fetch_done <= 1'b1;
            else fetch_y <= fetch_y + 1'b1;
          end else begin
            fetch_x <= fetch_x + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (push) fifo_mem[wr_ptr] <= mem.rdata.pix;
  end

  // one register stage, so syncs and enable are delayed to match the colour
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_hsync   <= 1'b1;
      vga_vsync   <= 1'b1;
      vga_de      <= 1'b0;
      vga_red     <= '0;
      vga_grn     <= '0;
      vga_blu     <= '0;
      error_count <= '0;
    end else begin
      vga_hsync <= hsync;
      vga_vsync <= vsync;
      vga_de    <= de;
      if (pop) begin
        vga_red <= head.red;
        vga_grn <= head.green;
        vga_blu <= head.blue;
      end else begin
        vga_red <= '0;  // blanking, or black on underflow
        vga_grn <= '0;
        vga_blu <= '0;
      end
      if (underflow && (error_count != '1)) error_count <= error_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tb/sram_model.sv */
// asynchronous sram model with combinational read and a clocked write for simulation
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  pixel_clk,
  input  logic                  ce_n,
  input  logic                  we_n,
  input  logic                  oe_n,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // power-up contents differ from word to word so unwritten reads look wrong
  initial begin
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      mem[i] = DATA_WIDTH'(i * 40503) ^ DATA_WIDTH'(16'hc3a5);
    end
  end

  // output follows the address while the chip is selected and enabled
  assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;

  always @(posedge pixel_clk) begin
    if (!ce_n && !we_n) begin
      mem[addr] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_gfx_pattern.sv */
// testbench for the pattern demo top that checks timing, pixel contents and underflow count
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_pattern;

  localparam int clk_period = 4;
  localparam int h_visible = 16;
  localparam int h_front = 2;
  localparam int h_sync = 4;
  localparam int h_back = 2;
  localparam int v_visible = 8;
  localparam int addr_width = 8;
  localparam int frame_cycles = (h_visible + h_front + h_sync + h_back) * (v_visible + 1 + 2 + 1);

  // each entry gives the starting mode, the final mode, whether the write is held and the frames
  localparam int n_entries = 5;
  localparam int tab_start [n_entries] = '{gfx_pkg::pat_gradient, gfx_pkg::pat_checker,
                                           gfx_pkg::pat_bars, gfx_pkg::pat_black,
                                           gfx_pkg::pat_bars};
  localparam int tab_mode [n_entries] = '{gfx_pkg::pat_gradient, gfx_pkg::pat_checker,
                                          gfx_pkg::pat_bars, gfx_pkg::pat_black,
                                          gfx_pkg::pat_gradient};
  localparam int tab_hold [n_entries] = '{0, 0, 0, 0, 1};
  localparam int tab_frames [n_entries] = '{2, 1, 1, 1, 2};

  logic                  pixel_clk;
  logic                  rst_n;
  logic                  continuous_write;
  logic [1:0]            pattern_mode;
  logic [15:0]           sram_rdata;
  logic [addr_width-1:0] sram_addr;
  logic [15:0]           sram_wdata;
  logic                  sram_ce_n;
  logic                  sram_we_n;
  logic                  sram_oe_n;
  logic [3:0]            vga_red;
  logic [3:0]            vga_grn;
  logic [3:0]            vga_blu;
  logic                  vga_hsync;
  logic                  vga_vsync;
  logic                  vga_de;
  logic                  write_busy;
  logic [15:0]           error_count;

  bit monitor_on = 1'b0;
  bit check_en = 1'b0;
  bit vsync_seen = 1'b0;
  bit prev_de = 1'b0;
  bit prev_vs = 1'b1;
  bit prev_hs = 1'b1;
  int check_mode = 0;
  int de_count = 0;
  int run_len = 0;
  int run_count = 0;
  int vsync_count = 0;
  int hs_gap = 0;  // cycles since the last falling edge of hsync

  gfx_pattern_top #(
    .H_VISIBLE (h_visible),
    .H_FRONT   (h_front),
    .H_SYNC    (h_sync),
    .H_BACK    (h_back),
    .V_VISIBLE (v_visible),
    .V_FRONT   (1),
    .V_SYNC    (2),
    .V_BACK    (1),
    .ADDR_WIDTH(addr_width),
    .FIFO_DEPTH(8)
  ) UUT (
    .pixel_clk       (pixel_clk),
    .rst_n           (rst_n),
    .continuous_write(continuous_write),
    .pattern_mode    (pattern_mode),
    .sram_rdata      (sram_rdata),
    .sram_addr       (sram_addr),
    .sram_wdata      (sram_wdata),
    .sram_ce_n       (sram_ce_n),
    .sram_we_n       (sram_we_n),
    .sram_oe_n       (sram_oe_n),
    .vga_red         (vga_red),
    .vga_grn         (vga_grn),
    .vga_blu         (vga_blu),
    .vga_hsync       (vga_hsync),
    .vga_vsync       (vga_vsync),
    .vga_de          (vga_de),
    .write_busy      (write_busy),
    .error_count     (error_count)
  );

  sram_model #(
    .ADDR_WIDTH(addr_width),
    .DATA_WIDTH(16)
  ) sram_i (
    .pixel_clk(pixel_clk),
    .ce_n     (sram_ce_n),
    .we_n     (sram_we_n),
    .oe_n     (sram_oe_n),
    .addr     (sram_addr),
    .wdata    (sram_wdata),
    .rdata    (sram_rdata)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #(clk_period / 2) pixel_clk = ~pixel_clk;
  end

  task automatic check_equal(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // colour as {red, green, blue} from the pattern rules
  function automatic int expected_pixel(input int mode, input int x, input int y);
    int r;
    int g;
    int b;
    r = 0;
    g = 0;
    b = 0;
    case (mode)
      gfx_pkg::pat_gradient: begin
        r = x % 16;
        g = y % 16;
        b = (x ^ y) & 15;
      end
      gfx_pkg::pat_checker: begin
        if (((x >> 2) & 1) != ((y >> 2) & 1)) begin
          r = 15;
          g = 15;
          b = 15;
        end
      end
      gfx_pkg::pat_bars: begin
        r = x % 16;
        g = x % 16;
        b = x % 16;
      end
      default: begin
      end
    endcase
    return (r << 8) | (g << 4) | b;
  endfunction

  task automatic check_reset_state();
    check_equal(int'(vga_hsync), 1, "vga_hsync in reset state");
    check_equal(int'(vga_vsync), 1, "vga_vsync in reset state");
    check_equal(int'(vga_de), 0, "vga_de in reset state");
    check_equal(int'(write_busy), 0, "write_busy in reset state");
    check_equal(int'(error_count), 0, "error_count in reset state");
    check_equal(int'(sram_ce_n), 1, "sram_ce_n in reset state");
    check_equal(int'(sram_we_n), 1, "sram_we_n in reset state");
    check_equal(int'(sram_oe_n), 1, "sram_oe_n in reset state");
  endtask

  task automatic pulse_write(input int mode);
    @(negedge pixel_clk);
    pattern_mode     = 2'(mode);
    continuous_write = 1'b1;
    @(negedge pixel_clk);
    continuous_write = 1'b0;
  endtask

  // the hold after the change spans more than one full pass, so a pass starts in the new mode
  task automatic hold_write(input int first_mode, input int final_mode);
    @(negedge pixel_clk);
    pattern_mode     = 2'(first_mode);
    continuous_write = 1'b1;
    repeat (100) @(negedge pixel_clk);
    pattern_mode = 2'(final_mode);
    repeat (2 * frame_cycles) @(negedge pixel_clk);
    continuous_write = 1'b0;
  endtask

  // the raster monitor samples half a cycle after the registered outputs change
  always @(negedge pixel_clk) begin : raster_monitor
    int px;
    int py;
    if (monitor_on) begin
      check_equal(int'(error_count), 0, "error_count");
      if (!vga_de) begin
        check_equal(int'({vga_red, vga_grn, vga_blu}), 0, "colour while vga_de is low");
      end else begin
        px = de_count % h_visible;
        py = de_count / h_visible;
        if (check_en) begin
          check_equal(int'({vga_red, vga_grn, vga_blu}), expected_pixel(check_mode, px, py),
                      $sformatf("pixel x %0d y %0d", px, py));
        end
        de_count++;
        run_len++;
      end
      if (prev_hs && !vga_hsync) begin
        hs_gap = 0;
      end else begin
        hs_gap++;
      end
      if (!prev_hs && vga_hsync) begin
        check_equal(hs_gap, h_sync, "hsync pulse width");
      end
      if (!prev_de && vga_de) begin
        check_equal(hs_gap, h_sync + h_back, "cycles from hsync to a visible run");
      end
      if (prev_de && !vga_de) begin
        check_equal(run_len, h_visible, "length of a visible run");
        run_len = 0;
        run_count++;
      end
      if (prev_vs && !vga_vsync) begin
        if (vsync_seen) begin
          check_equal(de_count, h_visible * v_visible, "enabled cycles per frame");
          check_equal(run_count, v_visible, "visible runs per frame");
        end
        de_count    = 0;
        run_count   = 0;
        vsync_seen  = 1'b1;
        vsync_count++;
      end
      prev_de = vga_de;
      prev_vs = vga_vsync;
      prev_hs = vga_hsync;
    end
  end

  initial begin
    longint budget_ns;
    budget_ns = 0;
    for (int i = 0; i < n_entries; i++) begin
      budget_ns += 2 * longint'(tab_frames[i] + 3) * frame_cycles * clk_period;
    end
    #(budget_ns);
    $display("timeout: the run did not finish within %0d ns", budget_ns);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int start;
    rst_n            = 1'b0;
    continuous_write = 1'b0;
    pattern_mode     = 2'd0;
    repeat (3) begin
      @(negedge pixel_clk);
      check_reset_state();
    end
    rst_n = 1'b1;
    @(posedge pixel_clk);
    monitor_on = 1'b1;
    @(negedge pixel_clk);
    check_reset_state();

    for (int i = 0; i < n_entries; i++) begin
      if (tab_hold[i] != 0) begin
        hold_write(tab_start[i], tab_mode[i]);
      end else begin
        pulse_write(tab_mode[i]);
      end
      while (write_busy) @(negedge pixel_clk);
      @(posedge pixel_clk);
      start = vsync_count;
      wait (vsync_count != start);
      check_mode = tab_mode[i];
      check_en   = 1'b1;
      start      = vsync_count;
      wait (vsync_count == start + tab_frames[i]);
      check_en = 1'b0;
      $display("entry %0d: mode %0d shown correctly for %0d frames", i, tab_mode[i],
               tab_frames[i]);
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/gfx_pkg.sv
common/sram_port_if.sv
hdl/vga_timing.sv
pattern/pattern_writer.sv
scanout/scanout_reader.sv
hdl/sram_arbiter.sv
hdl/gfx_pattern_top.sv
tb/sram_model.sv
tb/tb_gfx_pattern.sv
